// ==== Makefile ====
# Verilator build and run for the ALU pipeline testbench

VERILATOR ?= verilator
TOP       ?= alu_pipe_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# run from the project root so the stim file path resolves
run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^Test OK$$" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== src.f ====
src/pipe_pkg.sv
src/issue_if.sv
src/rf_dpram.sv
src/issue_stage.sv
src/execute_stage.sv
src/alu_pipe_top.sv
verification/alu_pipe_sva.sv
verification/alu_pipe_tb.sv

// ==== src/alu_pipe_top.sv ====
`timescale 1ns/1ps
// ALU pipeline top level
// issue/read stage feeding execute/writeback, two cycles issue to result

module alu_pipe_top (
   input  logic                            clk,
   input  logic                            rst,
   // instruction in
   input  logic                            issue_valid,
   input  pipe_pkg::alu_op_e               issue_op,
   input  logic [pipe_pkg::REG_ADDR_W-1:0] issue_rd,
   input  logic [pipe_pkg::REG_ADDR_W-1:0] issue_rs1,
   input  logic [pipe_pkg::REG_ADDR_W-1:0] issue_rs2,
   input  logic [pipe_pkg::DATA_W-1:0]     issue_imm,
   // result out
   output logic                            result_valid,
   output logic [pipe_pkg::REG_ADDR_W-1:0] result_rd,
   output logic [pipe_pkg::DATA_W-1:0]     result_data
);

   // issued instruction and its operands
   issue_if iss_bus ();

   // register read, write port fed back from the result register
   issue_stage u_issue (
      .clk         (clk),
      .rst         (rst),
      .issue_valid (issue_valid),
      .issue_op    (issue_op),
      .issue_rd    (issue_rd),
      .issue_rs1   (issue_rs1),
      .issue_rs2   (issue_rs2),
      .issue_imm   (issue_imm),
      .wb_we       (result_valid),
      .wb_addr     (result_rd),
      .wb_data     (result_data),
      .iss         (iss_bus.issue)
   );

   // ALU with forwarding and result register
   execute_stage u_exec (
      .clk          (clk),
      .rst          (rst),
      .iss          (iss_bus.exec),
      .result_valid (result_valid),
      .result_rd    (result_rd),
      .result_data  (result_data)
   );

endmodule

// ==== src/execute_stage.sv ====
`timescale 1ns/1ps
// execute stage
// forwards the previous result, runs the ALU and registers the result,
// which is both the pipeline output and the register file write port

module execute_stage (
   input  logic                            clk,
   input  logic                            rst,
   issue_if.exec                           iss,
   output logic                            result_valid,
   output logic [pipe_pkg::REG_ADDR_W-1:0] result_rd,
   output logic [pipe_pkg::DATA_W-1:0]     result_data
);
   import pipe_pkg::*;

   // previous result targets a source of the current instruction
   logic              fwd_a;
   logic              fwd_b;
   // operands after forwarding
   logic [DATA_W-1:0] op_a;
   logic [DATA_W-1:0] op_b;
   // ALU output
   logic [DATA_W-1:0] alu_out;

   ////////////////////////////////////////////////////////////////////////////
   // forwarding
   ////////////////////////////////////////////////////////////////////////////

   // the result register has not reached the RAM yet when a back-to-back
   // dependent instruction reads, so the RAM word is one write behind
   assign fwd_a = result_valid && (result_rd == iss.rs1);
   assign fwd_b = result_valid && (result_rd == iss.rs2);

   assign op_a = fwd_a ? result_data : iss.a;
   assign op_b = fwd_b ? result_data : iss.b;

   ////////////////////////////////////////////////////////////////////////////
   // ALU
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      case (iss.op)
         // arithmetic wraps at DATA_W bits
         OP_ADD:  alu_out = op_a + op_b;
         OP_SUB:  alu_out = op_a - op_b;
         // bitwise
         OP_AND:  alu_out = op_a & op_b;
         OP_OR:   alu_out = op_a | op_b;
         OP_XOR:  alu_out = op_a ^ op_b;
         // immediate forms
         OP_ADDI: alu_out = op_a + iss.imm;
         OP_LI:   alu_out = iss.imm;
         // unused encoding
         default: alu_out = '0;
      endcase
   end

   ////////////////////////////////////////////////////////////////////////////
   // result register
   ////////////////////////////////////////////////////////////////////////////

   // strobe, one cycle per result
   always_ff @(posedge clk) begin
      if (rst) begin
         result_valid <= 1'b0;
      end else begin
         result_valid <= iss.valid;
      end
   end

   // destination and data hold between results
   always_ff @(posedge clk) begin
      if (iss.valid) begin
         result_rd   <= iss.rd;
         result_data <= alu_out;
      end
   end

endmodule

// ==== src/issue_if.sv ====
`timescale 1ns/1ps
// issue to execute bundle
// one issued instruction plus the two operands read from the register file

interface issue_if;
   import pipe_pkg::*;

   // instruction strobe and fields, registered in issue
   logic                  valid;
   alu_op_e               op;
   logic [REG_ADDR_W-1:0] rd;
   logic [REG_ADDR_W-1:0] rs1;
   logic [REG_ADDR_W-1:0] rs2;
   logic [DATA_W-1:0]     imm;
   // register file read data, same cycle as valid
   logic [DATA_W-1:0]     a;
   logic [DATA_W-1:0]     b;

   // issue side drives everything
   modport issue (output valid, op, rd, rs1, rs2, imm, a, b);
   // execute side only samples
   modport exec  (input  valid, op, rd, rs1, rs2, imm, a, b);

endinterface

// ==== src/issue_stage.sv ====
`timescale 1ns/1ps
// issue and register read stage
// latches the incoming instruction and reads rs1 and rs2 from two
// identical register file copies, each written with every result

module issue_stage (
   input  logic                            clk,
   input  logic                            rst,
   input  logic                            issue_valid,
   input  pipe_pkg::alu_op_e               issue_op,
   input  logic [pipe_pkg::REG_ADDR_W-1:0] issue_rd,
   input  logic [pipe_pkg::REG_ADDR_W-1:0] issue_rs1,
   input  logic [pipe_pkg::REG_ADDR_W-1:0] issue_rs2,
   input  logic [pipe_pkg::DATA_W-1:0]     issue_imm,
   input  logic                            wb_we,
   input  logic [pipe_pkg::REG_ADDR_W-1:0] wb_addr,
   input  logic [pipe_pkg::DATA_W-1:0]     wb_data,
   issue_if.issue                          iss
);
   import pipe_pkg::*;

   // index width implied by the register count
   localparam int RF_AW = $clog2(NUM_REGS);

   ////////////////////////////////////////////////////////////////////////////
   // instruction register
   ////////////////////////////////////////////////////////////////////////////

   // strobe, one cycle per instruction
   always_ff @(posedge clk) begin
      if (rst) begin
         iss.valid <= 1'b0;
      end else begin
         iss.valid <= issue_valid;
      end
   end

   // fields only load on a real issue
   always_ff @(posedge clk) begin
      if (issue_valid) begin
         iss.op  <= issue_op;
         iss.rd  <= issue_rd;
         iss.rs1 <= issue_rs1;
         iss.rs2 <= issue_rs2;
         iss.imm <= issue_imm;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // register file, two copies for two read ports
   ////////////////////////////////////////////////////////////////////////////

   // copy a serves rs1
   rf_dpram #(
      .ADDR_WIDTH    (RF_AW),
      .DATA_WIDTH    (DATA_W),
      .CLEAR_ON_INIT (1'b1),
      .ENABLE_BYPASS (1'b1)
   ) rf_a (
      .clk   (clk),
      .raddr (issue_rs1),
      .re    (issue_valid),
      .waddr (wb_addr),
      .we    (wb_we),
      .din   (wb_data),
      .dout  (iss.a)
   );

   // copy b serves rs2, same write traffic keeps it equal to copy a
   rf_dpram #(
      .ADDR_WIDTH    (RF_AW),
      .DATA_WIDTH    (DATA_W),
      .CLEAR_ON_INIT (1'b1),
      .ENABLE_BYPASS (1'b1)
   ) rf_b (
      .clk   (clk),
      .raddr (issue_rs2),
      .re    (issue_valid),
      .waddr (wb_addr),
      .we    (wb_we),
      .din   (wb_data),
      .dout  (iss.b)
   );

endmodule

// ==== src/pipe_pkg.sv ====
// ALU pipeline package
// datapath widths, register count and the opcode set shared by the
// issue and execute stages

package pipe_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // sizes
   ////////////////////////////////////////////////////////////////////////////

   // register data and result width
   localparam int DATA_W     = 32;
   // register index width
   localparam int REG_ADDR_W = 5;
   // architectural registers, all general purpose
   localparam int NUM_REGS   = 32;

   ////////////////////////////////////////////////////////////////////////////
   // opcodes
   ////////////////////////////////////////////////////////////////////////////

   // register-register ops use rs1 and rs2, ADDI uses rs1 and imm, LI only imm
   typedef enum logic [2:0] {
      OP_ADD  = 3'd0,
      OP_SUB  = 3'd1,
      OP_AND  = 3'd2,
      OP_OR   = 3'd3,
      OP_XOR  = 3'd4,
      OP_ADDI = 3'd5,
      OP_LI   = 3'd6
   } alu_op_e;

endpackage

// ==== src/rf_dpram.sv ====
`timescale 1ns/1ps
// register file RAM
// single clock, one write port and one registered read port, optional
// zero fill at init and optional same-address write-to-read bypass

module rf_dpram #(
   parameter int ADDR_WIDTH    = 5,
   parameter int DATA_WIDTH    = 32,
   parameter bit CLEAR_ON_INIT = 1'b0,
   parameter bit ENABLE_BYPASS = 1'b1
) (
   input  logic                  clk,
   input  logic [ADDR_WIDTH-1:0] raddr,
   input  logic                  re,
   input  logic [ADDR_WIDTH-1:0] waddr,
   input  logic                  we,
   input  logic [DATA_WIDTH-1:0] din,
   output logic [DATA_WIDTH-1:0] dout
);

   localparam int DEPTH = 1 << ADDR_WIDTH;

   // storage array
   logic [DATA_WIDTH-1:0] mem [DEPTH];
   // array word captured on re
   logic [DATA_WIDTH-1:0] rdata;

   // write port
   always @(posedge clk) begin
      if (we) begin
         mem[waddr] <= din;
      end
   end

   // read port, holds last word while re is low
   always_ff @(posedge clk) begin
      if (re) begin
         rdata <= mem[raddr];
      end
   end

   generate
      if (CLEAR_ON_INIT) begin : g_clear
         // every word starts at zero
         initial begin
            for (int i = 0; i < DEPTH; i++) begin
               mem[i] = '0;
            end
         end
      end

      if (ENABLE_BYPASS) begin : g_bypass
         // write data seen on the read edge
         logic [DATA_WIDTH-1:0] din_r;
         // read collided with a write to the same word
         logic                  bypass;

         always_ff @(posedge clk) begin
            if (re) begin
               din_r  <= din;
               bypass <= we && (waddr == raddr);
            end
         end

         // array read returns the old word on a collision, take the new one
         assign dout = bypass ? din_r : rdata;
      end else begin : g_no_bypass
         assign dout = rdata;
      end
   endgenerate

endmodule

// ==== verification/alu_pipe_stim.txt ====
// gap op rd rs1 rs2 imm expected, all hex, one instruction per line
// gap is idle cycles before the issue; ffffffff in gap ends the list
0        6 01 00 00 00000010 00000010
1        6 02 00 00 fffffff0 fffffff0
2        6 03 00 00 0f0f0f0f 0f0f0f0f
1        6 04 00 00 80000000 80000000
3        0 05 01 02 00000000 00000000
3        1 06 01 02 00000000 00000020
0        2 07 02 03 00000000 0f0f0f00
0        3 08 01 03 00000000 0f0f0f1f
0        4 09 02 03 00000000 f0f0f0ff
0        5 0a 04 00 7fffffff ffffffff
0        0 0b 04 04 00000000 00000000
2        5 0c 01 00 00000005 00000015
0        0 0d 0c 0c 00000000 0000002a
0        1 0e 0d 01 00000000 0000001a
0        4 0f 03 0e 00000000 0f0f0f15
2        6 10 00 00 12345678 12345678
0        6 11 00 00 00000100 00000100
0        0 12 10 11 00000000 12345778
0        1 13 11 12 00000000 edcba988
1        0 14 1e 1f 00000000 00000000
0        5 15 1c 00 0000abcd 0000abcd
3        0 16 05 06 00000000 00000020
0        6 01 00 00 deadbeef deadbeef
0        5 17 01 00 00000001 deadbef0
4        2 18 01 09 00000000 d0a0b0ef
ffffffff 0 00 00 00 00000000 00000000

// ==== verification/alu_pipe_sva.sv ====
`timescale 1ns/1ps
// ALU pipeline assertions
// result strobe latency, reset state and result data integrity

module alu_pipe_sva (
   input logic                        clk,
   input logic                        rst,
   input logic                        issue_valid,
   input logic                        result_valid,
   input logic [pipe_pkg::DATA_W-1:0] result_data
);

   // every issue gives a result strobe two edges later, and nothing else does
   a_latency: assert property (@(posedge clk) disable iff (rst)
      result_valid == $past(issue_valid, 2))
      else $error("result_valid does not follow issue_valid by two cycles");

   // result register comes out of reset idle
   a_reset: assert property (@(posedge clk) rst |=> !result_valid)
      else $error("result_valid high in the cycle after reset");

   // data must be fully defined while strobed
   a_known: assert property (@(posedge clk) disable iff (rst)
      result_valid |-> !$isunknown(result_data))
      else $error("result_data has unknown bits while result_valid is high");

endmodule

bind alu_pipe_top alu_pipe_sva u_sva (
   .clk          (clk),
   .rst          (rst),
   .issue_valid  (issue_valid),
   .result_valid (result_valid),
   .result_data  (result_data)
);

// ==== verification/alu_pipe_tb.sv ====
`timescale 1ns/1ps
// ALU pipeline testbench
// issues instructions from the stim file and checks results in issue order

module alu_pipe_tb;
   import pipe_pkg::*;

   // words per stim line and end marker in the gap column
   localparam int          COLS      = 7;
   localparam int          MAX_LINES = 64;
   localparam logic [31:0] END_MARK  = 32'hffffffff;

   logic                  clk = 1'b0;
   logic                  rst;
   logic                  issue_valid;
   alu_op_e               issue_op;
   logic [REG_ADDR_W-1:0] issue_rd;
   logic [REG_ADDR_W-1:0] issue_rs1;
   logic [REG_ADDR_W-1:0] issue_rs2;
   logic [DATA_W-1:0]     issue_imm;
   logic                  result_valid;
   logic [REG_ADDR_W-1:0] result_rd;
   logic [DATA_W-1:0]     result_data;

   // raw stim words in file order
   logic [31:0] stim [MAX_LINES*COLS];
   // expected results with the oldest at the front
   logic [31:0] exp_rd_q [$];
   logic [31:0] exp_data_q [$];

   int n_lines     = 0;
   int n_done      = 0;
   int n_pass      = 0;
   int n_fail      = 0;
   int cycles      = 0;
   int cycle_limit = 0;

   alu_pipe_top uut (
      .clk          (clk),
      .rst          (rst),
      .issue_valid  (issue_valid),
      .issue_op     (issue_op),
      .issue_rd     (issue_rd),
      .issue_rs1    (issue_rs1),
      .issue_rs2    (issue_rs2),
      .issue_imm    (issue_imm),
      .result_valid (result_valid),
      .result_rd    (result_rd),
      .result_data  (result_data)
   );

   always #5 clk = ~clk;

   // mismatch prints one FAIL line and clears ok
   task automatic check_equal(input string name, input logic [31:0] got,
                              input logic [31:0] exp, inout bit ok);
      if (got !== exp) begin
         $display("FAIL %0d ns %s got %h expected %h", $time, name, got, exp);
         ok = 1'b0;
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // result monitor and cycle limit
   ////////////////////////////////////////////////////////////////////////////

   always @(posedge clk) begin
      bit ok;
      if (!rst && result_valid) begin
         if (exp_data_q.size() == 0) begin
            $display("result for r%0d arrived with no instruction outstanding", result_rd);
            n_fail++;
         end else begin
            ok = 1'b1;
            check_equal("result_rd", 32'(result_rd), exp_rd_q.pop_front(), ok);
            check_equal("result_data", result_data, exp_data_q.pop_front(), ok);
            n_done++;
            if (ok) begin
               n_pass++;
            end else begin
               n_fail++;
            end
            $display("test %0d r%0d = %h %s", n_done, result_rd, result_data,
                     ok ? "passed" : "failed");
         end
      end
   end

   // limit counts only cycles out of reset
   always @(posedge clk) begin
      if (!rst) begin
         cycles <= cycles + 1;
         if (cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, %0d results never arrived",
                     cycles, exp_data_q.size());
            $display("Test FAILED");
            $finish;
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // stimulus
   ////////////////////////////////////////////////////////////////////////////

   initial begin
      int base;
      int gap_sum;
      rst         <= 1'b1;
      issue_valid <= 1'b0;
      issue_op    <= OP_ADD;
      issue_rd    <= '0;
      issue_rs1   <= '0;
      issue_rs2   <= '0;
      issue_imm   <= '0;
      $readmemh("verification/alu_pipe_stim.txt", stim);
      // count lines up to the end marker and sum the gaps for the limit
      gap_sum = 0;
      while (n_lines < MAX_LINES && stim[n_lines*COLS] != END_MARK) begin
         gap_sum += stim[n_lines*COLS];
         n_lines++;
      end
      cycle_limit = gap_sum + n_lines + 20;
      repeat (3) @(posedge clk);
      rst <= 1'b0;
      for (int i = 0; i < n_lines; i++) begin
         base = i * COLS;
         repeat (stim[base]) begin
            @(posedge clk);
            issue_valid <= 1'b0;
         end
         @(posedge clk);
         issue_valid <= 1'b1;
         issue_op    <= alu_op_e'(stim[base+1][2:0]);
         issue_rd    <= stim[base+2][REG_ADDR_W-1:0];
         issue_rs1   <= stim[base+3][REG_ADDR_W-1:0];
         issue_rs2   <= stim[base+4][REG_ADDR_W-1:0];
         issue_imm   <= stim[base+5];
         exp_rd_q.push_back(stim[base+2]);
         exp_data_q.push_back(stim[base+6]);
      end
      @(posedge clk);
      issue_valid <= 1'b0;
      // wait for the queue to drain and a few more edges for any stray result
      while (exp_data_q.size() != 0) begin
         @(posedge clk);
      end
      repeat (3) @(posedge clk);
      $display("%0d instructions, %0d passed, %0d failed", n_lines, n_pass, n_fail);
      if (n_fail == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule
